/* rtl/cache_pkg.sv */
package cache_pkg;

	localparam int NUM_SETS        = 32;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int NUM_WAYS        = 2;

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  tag_t;      // Address bits 15:8
	typedef logic [4:0]  index_t;    // Address bits 7:3
	typedef logic [1:0]  word_sel_t; // Address bits 2:1

	typedef struct packed {
		logic  rd;
		logic  wr;
		addr_t addr;
		word_t data;
	} cpu_req_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_ENABLE,
		ST_WB0,
		ST_WB1,
		ST_WB2,
		ST_WB3,
		ST_REQ0,
		ST_REQ1,
		ST_REQ2_FILL0,
		ST_REQ3_FILL1,
		ST_FILL2,
		ST_FILL3,
		ST_DONE
	} ctrl_state_e;

	typedef struct packed {
		logic      enable;
		logic      comp;  // Lookup or write hit when set, fill when clear
		logic      write;
		index_t    index;
		tag_t      tag;
		word_sel_t word;
		word_t     wdata;
	} way_ctrl_t;

	typedef struct packed {
		logic  hit;   // Tag match, not qualified by valid
		logic  valid;
		logic  dirty;
		tag_t  tag;
		word_t rdata;
	} way_status_t;

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

	import cache_pkg::*;

	localparam int MEM_LATENCY = 2;  // Cycles from request to mem_rvalid
	localparam int NUM_BANKS   = 4;
	localparam int BANK_ROW_W  = 13; // Address bits 15:3
	localparam int BANK_DEPTH  = 1 << BANK_ROW_W;

	typedef enum logic [1:0] {
		MEM_NOP,
		MEM_RD,
		MEM_WR
	} mem_op_e;

	typedef struct packed {
		mem_op_e op;
		addr_t   addr;
		word_t   data;
	} mem_req_t;

endpackage

/* rtl/cache_way.sv */
`timescale 1ns/100ps

module cache_way
	import cache_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  way_ctrl_t   ctrl,
	output way_status_t status
);

	tag_t                tag_mem  [NUM_SETS];
	word_t               data_mem [NUM_SETS][WORDS_PER_BLOCK];
	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;

	logic tag_match;
	logic wr_en;

	// Lookup path, purely combinational
	assign tag_match = (tag_mem[ctrl.index] == ctrl.tag);

	assign status.hit   = ctrl.comp & tag_match;
	assign status.valid = valid_q[ctrl.index];
	assign status.dirty = dirty_q[ctrl.index];
	assign status.tag   = tag_mem[ctrl.index];
	assign status.rdata = data_mem[ctrl.index][ctrl.word];

	// A compare write only lands on a valid hit, a fill always lands
	assign wr_en = ctrl.enable & ctrl.write
		& (~ctrl.comp | (tag_match & valid_q[ctrl.index]));

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			if (ctrl.comp) begin
				dirty_q[ctrl.index] <= 1'b1; // CPU store
			end else begin
				valid_q[ctrl.index] <= 1'b1; // Fill from memory
				dirty_q[ctrl.index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[ctrl.index][ctrl.word] <= ctrl.wdata;
			if (!ctrl.comp) begin
				tag_mem[ctrl.index] <= ctrl.tag; // New owner of the set
			end
		end
	end

endmodule

/* rtl/banked_memory.sv */
`timescale 1ns/100ps

module banked_memory
	import cache_pkg::*, mem_pkg::*;
(
	input  logic     clk,
	input  mem_req_t mem_req,
	output word_t    mem_rdata,
	output logic     mem_rvalid
);

	typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;
	typedef logic [BANK_ROW_W-1:0]        bank_row_t;

	// Contents start at zero and survive reset
	word_t bank_mem [NUM_BANKS][BANK_DEPTH] = '{default: '0};

	logic [MEM_LATENCY-1:0] rd_valid_pipe = '0;
	addr_t                  rd_addr_q;
	word_t                  rd_data_pipe [MEM_LATENCY-1];

	bank_sel_t wr_bank;
	bank_row_t wr_row;
	bank_sel_t rd_bank;
	bank_row_t rd_row;

	// Interleave on word offset so a block spans all four banks
	assign wr_bank = mem_req.addr[2:1];
	assign wr_row  = mem_req.addr[15:3];
	assign rd_bank = rd_addr_q[2:1];
	assign rd_row  = rd_addr_q[15:3];

	always_ff @(posedge clk) begin
		if (mem_req.op == MEM_WR) begin
			bank_mem[wr_bank][wr_row] <= mem_req.data;
		end
	end

	// Stage 1 takes the address, stage 2 reads the bank
	always_ff @(posedge clk) begin
		rd_addr_q        <= mem_req.addr;
		rd_valid_pipe[0] <= (mem_req.op == MEM_RD);
		for (int i = 1; i < MEM_LATENCY; i++) begin
			rd_valid_pipe[i] <= rd_valid_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		rd_data_pipe[0] <= bank_mem[rd_bank][rd_row];
		for (int i = 1; i < MEM_LATENCY - 1; i++) begin
			rd_data_pipe[i] <= rd_data_pipe[i-1]; // Extra delay for longer latencies
		end
	end

	assign mem_rvalid = rd_valid_pipe[MEM_LATENCY-1];
	assign mem_rdata  = rd_data_pipe[MEM_LATENCY-2];

endmodule

/* rtl/cache_controller.sv */
`timescale 1ns/100ps

module cache_controller
	import cache_pkg::*, mem_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  cpu_req_t                   cpu_req,
	input  way_status_t [NUM_WAYS-1:0] way_status,
	input  word_t                      mem_rdata,
	input  logic                       mem_rvalid,
	output way_ctrl_t [NUM_WAYS-1:0]   way_ctrl,
	output mem_req_t                   mem_req,
	output word_t                      data_out,
	output logic                       done,
	output logic                       stall,
	output logic                       cache_hit,
	output logic                       err
);

	ctrl_state_e state, next_state;
	cpu_req_t    req_q;

	logic victim_q;   // Flips on every Compare
	logic fill_way_q; // Way chosen in Enable
	logic pick_way;
	logic pick_dirty;
	logic hit0, hit1, hit_any;
	logic accept, illegal, accept_ok;

	logic [NUM_WAYS-1:0] fill_sel;
	logic [NUM_WAYS-1:0] way_en;
	logic                way_comp;
	logic                way_write;
	logic                data_src; // Memory return when set, CPU word when clear
	logic                tag_src;  // Victim tag when set, request tag when clear
	word_sel_t           cache_word;
	word_sel_t           mem_word;
	mem_op_e             mem_op;

	tag_t   req_tag;
	index_t req_index;

	assign req_tag   = req_q.addr[15:8];
	assign req_index = req_q.addr[7:3];

	assign hit0    = way_status[0].hit & way_status[0].valid;
	assign hit1    = way_status[1].hit & way_status[1].valid;
	assign hit_any = hit0 | hit1;

	assign illegal   = (cpu_req.rd & cpu_req.wr) | cpu_req.addr[0];
	assign accept    = ~stall & (cpu_req.rd | cpu_req.wr);
	assign accept_ok = accept & ~illegal;

	// Replacement: invalid way 0, then invalid way 1, then victim bit
	assign pick_way = ~way_status[0].valid ? 1'b0
		: ~way_status[1].valid ? 1'b1
		: victim_q;
	assign pick_dirty = way_status[pick_way].valid & way_status[pick_way].dirty;

	assign fill_sel = NUM_WAYS'(1) << fill_way_q;

	assign done      = ((state == ST_COMPARE) & hit_any) | (state == ST_DONE);
	assign cache_hit = (state == ST_COMPARE) & hit_any;
	assign stall     = (state != ST_IDLE) & ~done;
	assign data_out  = hit1 ? way_status[1].rdata : way_status[0].rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_IDLE;
			victim_q   <= 1'b0;
			fill_way_q <= 1'b0;
			err        <= 1'b0;
		end else begin
			state <= next_state;
			err   <= accept & illegal; // Rejected, no access follows
			if (state == ST_COMPARE) begin
				victim_q <= ~victim_q;
			end
			if (state == ST_ENABLE) begin
				fill_way_q <= pick_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept_ok) begin
			req_q <= cpu_req;
		end
	end

	always_comb begin
		next_state = state;
		way_en     = '0;
		way_comp   = 1'b0;
		way_write  = 1'b0;
		data_src   = 1'b0;
		tag_src    = 1'b0;
		cache_word = req_q.addr[2:1];
		mem_word   = 2'd0;
		mem_op     = MEM_NOP;

		case (state)
			ST_IDLE: begin
				if (accept_ok) next_state = ST_COMPARE;
			end
			ST_COMPARE: begin
				way_en    = '1;
				way_comp  = 1'b1;
				way_write = req_q.wr; // Store on hit
				if (hit_any) begin
					next_state = accept_ok ? ST_COMPARE : ST_IDLE;
				end else begin
					next_state = ST_ENABLE;
				end
			end
			ST_ENABLE: begin
				next_state = pick_dirty ? ST_WB0 : ST_REQ0;
			end
			ST_WB0, ST_WB1, ST_WB2, ST_WB3: begin
				way_en     = fill_sel;
				tag_src    = 1'b1;
				mem_op     = MEM_WR;
				cache_word = word_sel_t'(state - ST_WB0);
				mem_word   = word_sel_t'(state - ST_WB0);
				next_state = (state == ST_WB3) ? ST_REQ0 : ctrl_state_e'(state + 1);
			end
			ST_REQ0, ST_REQ1: begin
				mem_op     = MEM_RD;
				mem_word   = word_sel_t'(state - ST_REQ0);
				next_state = ctrl_state_e'(state + 1);
			end
			ST_REQ2_FILL0, ST_REQ3_FILL1: begin
				mem_op     = MEM_RD;
				mem_word   = word_sel_t'(state - ST_REQ0);
				way_en     = fill_sel;
				way_write  = mem_rvalid;
				data_src   = 1'b1;
				cache_word = word_sel_t'(state - ST_REQ2_FILL0);
				next_state = ctrl_state_e'(state + 1);
			end
			ST_FILL2, ST_FILL3: begin
				way_en     = fill_sel;
				way_write  = mem_rvalid;
				data_src   = 1'b1;
				cache_word = word_sel_t'(state - ST_REQ2_FILL0);
				next_state = (state == ST_FILL3) ? ST_DONE : ST_FILL3;
			end
			ST_DONE: begin
				way_en     = '1;
				way_comp   = 1'b1;
				way_write  = req_q.wr; // Filled way hits now
				next_state = accept_ok ? ST_COMPARE : ST_IDLE;
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_ctrl[w].enable = way_en[w];
			way_ctrl[w].comp   = way_comp;
			way_ctrl[w].write  = way_write;
			way_ctrl[w].index  = req_index;
			way_ctrl[w].tag    = req_tag;
			way_ctrl[w].word   = cache_word;
			way_ctrl[w].wdata  = data_src ? mem_rdata : req_q.data;
		end
	end

	assign mem_req.op   = mem_op;
	assign mem_req.addr = {tag_src ? way_status[fill_way_q].tag : req_tag,
		req_index, mem_word, 1'b0};
	assign mem_req.data = way_status[fill_way_q].rdata; // Victim word on write-back

endmodule

/* rtl/mem_system.sv */
`timescale 1ns/100ps

module mem_system
	import cache_pkg::*, mem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  cpu_req_t cpu_req,
	output word_t    data_out,
	output logic     done,
	output logic     stall,
	output logic     cache_hit,
	output logic     err
);

	way_ctrl_t   [NUM_WAYS-1:0] way_ctrl;
	way_status_t [NUM_WAYS-1:0] way_status;
	mem_req_t                   mem_req;
	word_t                      mem_rdata;
	logic                       mem_rvalid;

	cache_controller u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.way_status (way_status),
		.mem_rdata  (mem_rdata),
		.mem_rvalid (mem_rvalid),
		.way_ctrl   (way_ctrl),
		.mem_req    (mem_req),
		.data_out   (data_out),
		.done       (done),
		.stall      (stall),
		.cache_hit  (cache_hit),
		.err        (err)
	);

	cache_way u_way0 (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (way_ctrl[0]),
		.status (way_status[0])
	);

	cache_way u_way1 (
		.clk    (clk),
		.reset  (reset),
		.ctrl   (way_ctrl[1]),
		.status (way_status[1])
	);

	// Backing store, no reset
	banked_memory u_mem (
		.clk        (clk),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_rvalid (mem_rvalid)
	);

endmodule

/* sim/mem_system_tb.sv */
`timescale 1ns/100ps

module mem_system_tb
	import cache_pkg::*;
();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_DIRECTED = 11;
	localparam int NUM_RANDOM   = 400;
	localparam int MAX_CYCLES   = 15; // Per request, above a dirty miss plus gap
	localparam int WATCHDOG_NS  =
		((NUM_DIRECTED + NUM_RANDOM) * MAX_CYCLES + RESET_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		logic       illegal;
		logic       hit;
		logic       is_read;
		word_t      rdata;
		logic [3:0] cycles; // Done cycle counted from acceptance
	} expect_t;

	logic     clk;
	logic     reset;
	cpu_req_t cpu_req;
	word_t    data_out;
	logic     done;
	logic     stall;
	logic     cache_hit;
	logic     err;

	integer  seed      = 32'hc1544c51;
	int      issued    = 0;
	int      completed = 0;
	expect_t exp_q [$];

	// Shadow state of the reference model
	word_t shadow_mem   [1 << 15]; // Indexed by address bits 15:1
	tag_t  shadow_tag   [2][NUM_SETS];
	logic  shadow_valid [2][NUM_SETS];
	logic  shadow_dirty [2][NUM_SETS];
	logic  shadow_victim;

	mem_system DUT (
		.clk       (clk),
		.reset     (reset),
		.cpu_req   (cpu_req),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic cpu_req_t make_req(input logic rd, input logic wr,
		input addr_t addr, input word_t data);
		cpu_req_t r;
		r.rd   = rd;
		r.wr   = wr;
		r.addr = addr;
		r.data = data;
		return r;
	endfunction

	task automatic clear_model();
		foreach (shadow_mem[i]) shadow_mem[i] = '0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				shadow_valid[w][s] = 1'b0;
				shadow_dirty[w][s] = 1'b0;
				shadow_tag[w][s]   = '0;
			end
		end
		shadow_victim = 1'b0;
	endtask

	// Two-way write-back cache over a flat memory that serves one request at a time
	function automatic expect_t model_access(input cpu_req_t req);
		expect_t e;
		tag_t    t;
		index_t  ix;
		int      way;
		e = '0;
		if ((req.rd && req.wr) || req.addr[0]) begin
			e.illegal = 1'b1;
			return e;
		end
		t  = req.addr[15:8];
		ix = req.addr[7:3];
		shadow_victim = ~shadow_victim; // Flips before the fill way is chosen
		e.is_read = req.rd;
		if (shadow_valid[0][ix] && shadow_tag[0][ix] == t) begin
			way    = 0;
			e.hit  = 1'b1;
		end else if (shadow_valid[1][ix] && shadow_tag[1][ix] == t) begin
			way    = 1;
			e.hit  = 1'b1;
		end else begin
			if (!shadow_valid[0][ix])
				way = 0;
			else if (!shadow_valid[1][ix])
				way = 1;
			else
				way = shadow_victim;
			e.cycles = (shadow_valid[way][ix] && shadow_dirty[way][ix]) ? 4'd13 : 4'd9;
			shadow_valid[way][ix] = 1'b1;
			shadow_tag[way][ix]   = t;
			shadow_dirty[way][ix] = 1'b0;
		end
		if (e.hit)
			e.cycles = 4'd1;
		if (req.wr) begin
			shadow_dirty[way][ix]       = 1'b1;
			shadow_mem[req.addr[15:1]]  = req.data;
		end
		e.rdata = shadow_mem[req.addr[15:1]];
		return e;
	endfunction

	// Runs from a falling edge and presents the request once stall is low
	task automatic issue(input cpu_req_t req);
		while (stall) @(negedge clk);
		cpu_req = req;
		exp_q.push_back(model_access(req));
		issued++;
		@(negedge clk);
		cpu_req = '0;
	endtask

	initial begin : drive_proc
		cpu_req_t    req;
		logic [31:0] rnd;
		int          roll;
		reset   = 1'b1;
		cpu_req = '0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		issue(make_req(1'b1, 1'b0, 16'h0010, 16'h0000)); // Cold miss reads zero
		issue(make_req(1'b1, 1'b0, 16'h0010, 16'h0000)); // Repeat hits
		issue(make_req(1'b0, 1'b1, 16'h0012, 16'hbeef));
		issue(make_req(1'b1, 1'b0, 16'h0012, 16'h0000));
		issue(make_req(1'b1, 1'b0, 16'h0014, 16'h0000)); // Neighbour word still zero
		issue(make_req(1'b1, 1'b0, 16'h0110, 16'h0000)); // Second tag into way 1
		issue(make_req(1'b1, 1'b0, 16'h0210, 16'h0000)); // Third tag evicts way 1
		issue(make_req(1'b1, 1'b1, 16'h0010, 16'h1234)); // Read and write together
		issue(make_req(1'b0, 1'b1, 16'h0013, 16'h5678)); // Odd address
		issue(make_req(1'b1, 1'b0, 16'h0310, 16'h0000)); // Evicts dirty tag 0
		issue(make_req(1'b1, 1'b0, 16'h0012, 16'h0000)); // Written word from memory

		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd  = $random(seed);
			roll = $unsigned($random(seed)) % 100;
			req.addr = {6'b0, rnd[1:0], 3'b0, rnd[3:2], rnd[5:4], 1'b0};
			req.data = rnd[31:16];
			req.rd   = rnd[6];
			req.wr   = ~rnd[6];
			if (roll < 3) begin
				req.rd = 1'b1;
				req.wr = 1'b1;
			end else if (roll < 5) begin
				req.addr[0] = 1'b1;
			end
			if (rnd[8:7] == 2'b00)
				@(negedge clk); // Idle gap now and then
			issue(req);
		end

		while (completed != issued) @(posedge clk);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

	// Outputs are sampled on the rising edge before the DUT updates
	initial begin : compare_proc
		expect_t cur;
		logic    busy;
		int      elapsed;
		busy    = 1'b0;
		elapsed = 0;
		cur     = '0;
		@(negedge reset);
		forever begin
			@(posedge clk);
			if (busy) begin
				elapsed++;
				if (cur.illegal) begin
					check_flag("err", err, 1'b1);
					check_flag("done", done, 1'b0);
					check_flag("stall", stall, 1'b0);
					busy = 1'b0;
					completed++;
				end else if (elapsed < cur.cycles) begin
					if (done)
						abort_run("done arrived before the expected cycle");
					check_flag("stall", stall, 1'b1);
					check_flag("err", err, 1'b0);
				end else begin
					if (!done)
						abort_run("done did not arrive in the expected cycle");
					check_flag("stall", stall, 1'b0);
					check_flag("cache_hit", cache_hit, cur.hit);
					check_flag("err", err, 1'b0);
					if (cur.is_read)
						check_word("data_out", data_out, cur.rdata);
					busy = 1'b0;
					completed++;
				end
			end else begin
				check_flag("done", done, 1'b0); // Nothing in flight
				check_flag("err", err, 1'b0);
				check_flag("stall", stall, 1'b0);
				check_flag("cache_hit", cache_hit, 1'b0);
			end
			if ((cpu_req.rd || cpu_req.wr) && !stall) begin
				cur     = exp_q.pop_front();
				busy    = 1'b1;
				elapsed = 0;
			end
		end
	end

	initial begin : watchdog_proc
		#(WATCHDOG_NS);
		$display("Watchdog expired before all requests completed");
		$display("Test FAILED");
		$fatal(1);
	end

endmodule

/* mem_system.f */
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/cache_way.sv
rtl/banked_memory.sv
rtl/cache_controller.sv
rtl/mem_system.sv
sim/mem_system_tb.sv
